/* verilog/wb_pkg.sv */
////////////////////////////////////////
// Shared widths and types for the block write path
// Byte addresses, one full-width beat per AXI write
////////////////////////////////////////

package wb_pkg;

    ////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;
    localparam int CNT_W  = 16;

    ////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////

    typedef logic [ADDR_W-1:0] wb_addr_t;
    typedef logic [DATA_W-1:0] wb_data_t;
    typedef logic [STRB_W-1:0] wb_strb_t;
    typedef logic [CNT_W-1:0]  wb_cnt_t;

    // Address step between consecutive beats of a block
    localparam wb_addr_t BEAT_BYTES = 32'd8;

    // One beat as it moves from stage to stage
    typedef struct packed {
        wb_addr_t addr;
        wb_data_t data;
        wb_strb_t strb;
    } wb_beat_t;

    ////////////////////////////////////////
    // Write response
    ////////////////////////////////////////

    typedef logic [1:0] wb_resp_t;

    // SLVERR and DECERR both have bit 1 set
    localparam wb_resp_t RESP_OKAY = 2'b00;

endpackage

/* verilog/wb_addr_gen.sv */
////////////////////////////////////////
// Start is ignored while busy; count must be nonzero
// One beat of output buffering, one cycle latency
////////////////////////////////////////

`timescale 1ns/1ps

module wb_addr_gen (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  wb_pkg::wb_addr_t  base,
    input  wb_pkg::wb_cnt_t   count,
    input  logic              data_valid,
    input  wb_pkg::wb_data_t  data,
    input  wb_pkg::wb_strb_t  strb,
    output logic              data_ready,
    output logic              busy,
    output logic              a_valid,
    output wb_pkg::wb_beat_t  a_beat,
    input  logic              a_ready
);

    import wb_pkg::*;

    wb_addr_t next_addr;
    wb_cnt_t  remain;
    logic     take;
    logic     out_free;

    // Output slot is empty or drains this cycle
    assign out_free   = !a_valid || a_ready;
    assign data_ready = busy && (remain != '0) && out_free;
    assign take       = data_valid && data_ready;

    ////////////////////////////////////////
    // Block control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            next_addr <= '0;
            remain    <= '0;
        end else if (!busy) begin
            if (start) begin
                busy      <= 1'b1;
                next_addr <= base;
                remain    <= count;
            end
        end else begin
            if (take) begin
                next_addr <= next_addr + BEAT_BYTES;
                remain    <= remain - 1'b1;
            end
            // Last beat handed to the FIFO
            if (remain == '0 && a_valid && a_ready) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            a_valid <= 1'b0;
        end else if (take) begin
            a_valid <= 1'b1;
        end else if (a_ready) begin
            a_valid <= 1'b0;
        end
    end

    // Payload, tagged with the address of this word
    always_ff @(posedge clk) begin
        if (take) begin
            a_beat.addr <= next_addr;
            a_beat.data <= data;
            a_beat.strb <= strb;
        end
    end

endmodule

/* verilog/wb_beat_fifo.sv */
////////////////////////////////////////
// FIFO_DEPTH must be a power of two
// Two cycles from write to f_valid when empty
////////////////////////////////////////

`timescale 1ns/1ps

module wb_beat_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              a_valid,
    input  wb_pkg::wb_beat_t  a_beat,
    output logic              a_ready,
    output logic              f_valid,
    output wb_pkg::wb_beat_t  f_beat,
    input  logic              f_ready
);

    import wb_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    // Extra top bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    wb_beat_t mem [FIFO_DEPTH];
    wb_beat_t rd_data;
    logic     rd_valid;

    logic full;
    logic empty;
    logic write;
    logic read;
    logic store_out;

    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign a_ready = !full;
    assign write   = a_valid && !full;

    // Output register loads when empty or being taken
    assign store_out = f_ready || !f_valid;
    // Refill the read stage whenever it will be empty next cycle
    assign read = !empty && (store_out || !rd_valid);

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr[AW-1:0]] <= a_beat;
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (store_out || !rd_valid) begin
                rd_valid <= !empty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            rd_data <= mem[rd_ptr[AW-1:0]];
        end
    end

    // Output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            f_valid <= 1'b0;
        end else if (store_out) begin
            f_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (store_out) begin
            f_beat <= rd_data;
        end
    end

endmodule

/* verilog/wb_axi_issue.sv */
////////////////////////////////////////
// One single-beat write in flight on AW/W
// Slave may take AW and W in any order
////////////////////////////////////////

`timescale 1ns/1ps

module wb_axi_issue #(
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              f_valid,
    input  wb_pkg::wb_beat_t  f_beat,
    output logic              f_ready,
    input  logic              credit_ok,
    output logic              launch,
    output wb_pkg::wb_addr_t  m_axi_awaddr,
    output logic              m_axi_awvalid,
    input  logic              m_axi_awready,
    output wb_pkg::wb_data_t  m_axi_wdata,
    output wb_pkg::wb_strb_t  m_axi_wstrb,
    output logic              m_axi_wvalid,
    input  logic              m_axi_wready
);

    import wb_pkg::*;

    if (MAX_OUTSTANDING < 1) begin : g_bad_credit
        $error("wb_axi_issue needs MAX_OUTSTANDING of at least 1");
    end

    wb_beat_t ent;
    logic     aw_pend;
    logic     w_pend;
    logic     aw_done;
    logic     w_done;

    // Channel finished, or finishing on this edge
    assign aw_done = !aw_pend || m_axi_awready;
    assign w_done  = !w_pend || m_axi_wready;

    assign f_ready = aw_done && w_done && credit_ok;
    assign launch  = f_valid && f_ready;

    ////////////////////////////////////////
    // Pending flags, one per channel
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else if (launch) begin
            aw_pend <= 1'b1;
            w_pend  <= 1'b1;
        end else begin
            if (m_axi_awready) begin
                aw_pend <= 1'b0;
            end
            if (m_axi_wready) begin
                w_pend <= 1'b0;
            end
        end
    end

    // Entry stays put until both channels complete
    always_ff @(posedge clk) begin
        if (launch) begin
            ent <= f_beat;
        end
    end

    assign m_axi_awvalid = aw_pend;
    assign m_axi_awaddr  = ent.addr;
    assign m_axi_wvalid  = w_pend;
    assign m_axi_wdata   = ent.data;
    assign m_axi_wstrb   = ent.strb;

endmodule

/* verilog/wb_resp_track.sv */
////////////////////////////////////////
// B is always accepted; responses arrive in order
// Counters wrap at 2**CNT_W
////////////////////////////////////////

`timescale 1ns/1ps

module wb_resp_track #(
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              launch,
    input  logic              m_axi_bvalid,
    input  wb_pkg::wb_resp_t  m_axi_bresp,
    output logic              m_axi_bready,
    output logic              credit_ok,
    output wb_pkg::wb_cnt_t   resp_count,
    output wb_pkg::wb_cnt_t   err_count
);

    localparam int OW = $clog2(MAX_OUTSTANDING + 1);

    logic [OW-1:0] outstanding;
    logic          b_hs;

    assign b_hs      = m_axi_bvalid && m_axi_bready;
    assign credit_ok = outstanding < OW'(MAX_OUTSTANDING);

    // Ready comes up on the first cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            m_axi_bready <= 1'b0;
        end else begin
            m_axi_bready <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Writes in flight
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= '0;
        end else begin
            case ({launch, b_hs})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Totals, bit 1 of bresp marks an error
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_count <= '0;
            err_count  <= '0;
        end else if (b_hs) begin
            resp_count <= resp_count + 1'b1;
            if (m_axi_bresp[1]) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

endmodule

/* verilog/wb_write_path.sv */
////////////////////////////////////////
// Fixed AXI fields are tied outside this block
// FIFO_DEPTH must be a power of two
////////////////////////////////////////

`timescale 1ns/1ps

module wb_write_path #(
    parameter int FIFO_DEPTH      = 16,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic              clk,
    input  logic              rst,
    // Client
    input  logic              start,
    input  wb_pkg::wb_addr_t  base,
    input  wb_pkg::wb_cnt_t   count,
    output logic              busy,
    input  logic              data_valid,
    input  wb_pkg::wb_data_t  data,
    input  wb_pkg::wb_strb_t  strb,
    output logic              data_ready,
    // AXI write channels
    output wb_pkg::wb_addr_t  m_axi_awaddr,
    output logic              m_axi_awvalid,
    input  logic              m_axi_awready,
    output wb_pkg::wb_data_t  m_axi_wdata,
    output wb_pkg::wb_strb_t  m_axi_wstrb,
    output logic              m_axi_wvalid,
    input  logic              m_axi_wready,
    input  wb_pkg::wb_resp_t  m_axi_bresp,
    input  logic              m_axi_bvalid,
    output logic              m_axi_bready,
    // Status
    output wb_pkg::wb_cnt_t   resp_count,
    output wb_pkg::wb_cnt_t   err_count
);

    import wb_pkg::*;

    wb_beat_t a_beat;
    logic     a_valid;
    logic     a_ready;
    wb_beat_t f_beat;
    logic     f_valid;
    logic     f_ready;
    logic     launch;
    logic     credit_ok;

    wb_addr_gen u_addr_gen (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .base       (base),
        .count      (count),
        .data_valid (data_valid),
        .data       (data),
        .strb       (strb),
        .data_ready (data_ready),
        .busy       (busy),
        .a_valid    (a_valid),
        .a_beat     (a_beat),
        .a_ready    (a_ready)
    );

    wb_beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_beat_fifo (
        .clk     (clk),
        .rst     (rst),
        .a_valid (a_valid),
        .a_beat  (a_beat),
        .a_ready (a_ready),
        .f_valid (f_valid),
        .f_beat  (f_beat),
        .f_ready (f_ready)
    );

    wb_axi_issue #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_axi_issue (
        .clk           (clk),
        .rst           (rst),
        .f_valid       (f_valid),
        .f_beat        (f_beat),
        .f_ready       (f_ready),
        .credit_ok     (credit_ok),
        .launch        (launch),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_wdata   (m_axi_wdata),
        .m_axi_wstrb   (m_axi_wstrb),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready)
    );

    wb_resp_track #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_resp_track (
        .clk          (clk),
        .rst          (rst),
        .launch       (launch),
        .m_axi_bvalid (m_axi_bvalid),
        .m_axi_bresp  (m_axi_bresp),
        .m_axi_bready (m_axi_bready),
        .credit_ok    (credit_ok),
        .resp_count   (resp_count),
        .err_count    (err_count)
    );

endmodule

/* test/tb_axi_mem.sv */
////////////////////////////////////////
// AXI write slave over 64 KiB using address bits 15:0
// Random AW/W stalls, in-order B, SLVERR at 0xF000-0xFFFF
////////////////////////////////////////

`timescale 1ns/1ps

module tb_axi_mem #(
    parameter int MAX_OUTSTANDING = 4,
    parameter int SEED            = 32'hf8cc
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [6:0]        stall_pct,
    input  wb_pkg::wb_addr_t  awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  wb_pkg::wb_data_t  wdata,
    input  wb_pkg::wb_strb_t  wstrb,
    input  logic              wvalid,
    output logic              wready,
    output wb_pkg::wb_resp_t  bresp,
    output logic              bvalid,
    input  logic              bready,
    output logic              overrun
);

    import wb_pkg::*;

    localparam wb_resp_t RESP_SLVERR = 2'b10;

    logic [7:0] mem [65536];
    wb_addr_t   aw_q [$];
    wb_data_t   wd_q [$];
    wb_strb_t   ws_q [$];
    wb_resp_t   br_q [$];
    int         due_q [$];
    integer     seed = SEED;
    int         cyc;
    int         in_flight;
    int         last_due;

    // Fill pattern over the whole 16-bit address
    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i ^ (i >> 8) ^ 8'h5a);
        end
    end

    // Outputs idle before the first clock edge
    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = RESP_OKAY;
        overrun = 1'b0;
    end

    always @(posedge clk) begin : slave_step
        wb_addr_t a;
        wb_data_t d;
        wb_strb_t s;
        int       dly;
        if (rst) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= RESP_OKAY;
            overrun   <= 1'b0;
            cyc       = 0;
            in_flight = 0;
            last_due  = 0;
            aw_q.delete();
            wd_q.delete();
            ws_q.delete();
            br_q.delete();
            due_q.delete();
        end else begin
            cyc = cyc + 1;
            if (awvalid && awready) begin
                aw_q.push_back(awaddr);
                in_flight = in_flight + 1;
            end
            if (wvalid && wready) begin
                wd_q.push_back(wdata);
                ws_q.push_back(wstrb);
            end
            if (bvalid && bready) begin
                br_q.pop_front();
                due_q.pop_front();
                in_flight = in_flight - 1;
            end
            if (in_flight > MAX_OUTSTANDING) begin
                overrun <= 1'b1;
            end
            // AW and W pair up strictly in arrival order
            while (aw_q.size() > 0 && wd_q.size() > 0) begin
                a = aw_q.pop_front();
                d = wd_q.pop_front();
                s = ws_q.pop_front();
                for (int k = 0; k < STRB_W; k++) begin
                    if (s[k]) begin
                        mem[16'(a[15:0] + k)] = d[8*k +: 8];
                    end
                end
                dly = $unsigned($random(seed)) % 6;
                // Never let a later response overtake an earlier one
                last_due = (cyc + dly > last_due) ? cyc + dly : last_due;
                due_q.push_back(last_due);
                br_q.push_back((a[15:12] == 4'hf) ? RESP_SLVERR : RESP_OKAY);
            end
            awready <= ($unsigned($random(seed)) % 100) >= stall_pct;
            wready  <= ($unsigned($random(seed)) % 100) >= stall_pct;
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                bvalid <= 1'b1;
                bresp  <= br_q[0];
            end else begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

/* test/tb_wb_write_path.sv */
////////////////////////////////////////
// Random blocks against a byte-image model
// Stops at the first error
////////////////////////////////////////

`timescale 1ns/1ps

module tb_wb_write_path;

    import wb_pkg::*;

    localparam int FIFO_DEPTH      = 16;
    localparam int MAX_OUTSTANDING = 4;

    logic clk;
    logic rst;
    logic start;
    wb_addr_t base;
    wb_cnt_t count;
    logic busy;
    logic data_valid;
    wb_data_t data;
    wb_strb_t strb;
    logic data_ready;
    wb_addr_t m_axi_awaddr;
    logic m_axi_awvalid;
    logic m_axi_awready;
    wb_data_t m_axi_wdata;
    wb_strb_t m_axi_wstrb;
    logic m_axi_wvalid;
    logic m_axi_wready;
    wb_resp_t m_axi_bresp;
    logic m_axi_bvalid;
    logic m_axi_bready;
    wb_cnt_t resp_count;
    wb_cnt_t err_count;
    logic [6:0] stall_pct;
    logic slave_overrun;

    // Reference model state
    logic [7:0] exp_mem [65536];
    wb_cnt_t exp_resp;
    wb_cnt_t exp_err;
    integer seed = 32'hf8cc;
    int beats_sent;
    int cycles;
    bit saw_stall;

    wb_write_path #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) DUT (
        .clk (clk), .rst (rst), .start (start), .base (base), .count (count),
        .busy (busy), .data_valid (data_valid), .data (data), .strb (strb),
        .data_ready (data_ready), .m_axi_awaddr (m_axi_awaddr),
        .m_axi_awvalid (m_axi_awvalid), .m_axi_awready (m_axi_awready),
        .m_axi_wdata (m_axi_wdata), .m_axi_wstrb (m_axi_wstrb),
        .m_axi_wvalid (m_axi_wvalid), .m_axi_wready (m_axi_wready),
        .m_axi_bresp (m_axi_bresp), .m_axi_bvalid (m_axi_bvalid),
        .m_axi_bready (m_axi_bready), .resp_count (resp_count), .err_count (err_count)
    );

    tb_axi_mem #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) slave (
        .clk (clk), .rst (rst), .stall_pct (stall_pct),
        .awaddr (m_axi_awaddr), .awvalid (m_axi_awvalid), .awready (m_axi_awready),
        .wdata (m_axi_wdata), .wstrb (m_axi_wstrb), .wvalid (m_axi_wvalid),
        .wready (m_axi_wready), .bresp (m_axi_bresp), .bvalid (m_axi_bvalid),
        .bready (m_axi_bready), .overrun (slave_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Failure, compare and model helpers
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string what, input wb_addr_t a,
                              input wb_data_t exp, input wb_data_t act);
        if (exp !== act) begin
            abort_run($sformatf("mismatch %s at %h: expected %h, actual %h",
                                what, a, exp, act));
        end
    endtask

    task automatic check_cnt(input string what, input wb_cnt_t exp, input wb_cnt_t act);
        if (exp !== act) begin
            abort_run($sformatf("mismatch %s: expected %0d, actual %0d", what, exp, act));
        end
    endtask

    function automatic wb_data_t model_word(input int a);
        wb_data_t w;
        for (int k = 0; k < STRB_W; k++) begin
            w[8*k +: 8] = exp_mem[16'(a + k)];
        end
        return w;
    endfunction

    function automatic wb_data_t slave_word(input int a);
        wb_data_t w;
        for (int k = 0; k < STRB_W; k++) begin
            w[8*k +: 8] = slave.mem[16'(a + k)];
        end
        return w;
    endfunction

    // Expected image, response total and error total
    task automatic model_write(input wb_addr_t a, input wb_data_t d, input wb_strb_t s);
        for (int k = 0; k < STRB_W; k++) begin
            if (s[k]) begin
                exp_mem[16'(a[15:0] + k)] = d[8*k +: 8];
            end
        end
        exp_resp = exp_resp + 1'b1;
        if (a[15:12] == 4'hf) begin
            exp_err = exp_err + 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic wait_idle();
        @(negedge clk);
        while (busy) @(negedge clk);
    endtask

    task automatic pulse_start(input wb_addr_t b, input wb_cnt_t n);
        @(posedge clk);
        start <= 1'b1;
        base  <= b;
        count <= n;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic set_stall(input int pct);
        @(posedge clk);
        stall_pct <= 7'(pct);
    endtask

    // Returns on the negedge before the edge that accepts the word
    task automatic send_word(input wb_data_t d, input wb_strb_t s);
        @(posedge clk);
        data_valid <= 1'b1;
        data       <= d;
        strb       <= s;
        @(negedge clk);
        while (!data_ready) @(negedge clk);
    endtask

    // A nonzero ignored base is pulsed again while the block is busy
    task automatic run_block(input wb_addr_t b, input wb_cnt_t n, input bit full,
                             input bit gaps, input wb_addr_t ignored);
        wb_data_t d;
        wb_strb_t s;
        wait_idle();
        pulse_start(b, n);
        @(negedge clk);
        if (!busy) begin
            abort_run("busy did not rise after a start pulse");
        end
        beats_sent = beats_sent + n;
        if (ignored != '0) begin
            pulse_start(ignored, 16'd5);
        end
        for (int i = 0; i < n; i++) begin
            d = {$random(seed), $random(seed)};
            s = full ? '1 : wb_strb_t'($random(seed));
            model_write(b + i * BEAT_BYTES, d, s);
            if (gaps && ($unsigned($random(seed)) % 4 == 0)) begin
                @(posedge clk);
                data_valid <= 1'b0;
            end
            send_word(d, s);
        end
        @(posedge clk);
        data_valid <= 1'b0;
        // Last beat still sits in the address stage here
        @(negedge clk);
        if (!busy) begin
            abort_run("busy fell before the last beat reached the FIFO");
        end
    endtask

    task automatic finish_test(input string name);
        wait_idle();
        while (resp_count < exp_resp) @(negedge clk);
        check_cnt({name, " resp_count"}, exp_resp, resp_count);
        check_cnt({name, " err_count"}, exp_err, err_count);
        for (int w = 0; w < 65536; w += 8) begin
            check_data(name, wb_addr_t'(w), model_word(w), slave_word(w));
        end
    endtask

    function automatic wb_addr_t rand_base();
        return wb_addr_t'(($unsigned($random(seed)) % 1024) * 8);
    endfunction

    function automatic wb_cnt_t rand_count();
        return wb_cnt_t'(1 + $unsigned($random(seed)) % 24);
    endfunction

    ////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (busy && data_valid && !data_ready) begin
            saw_stall = 1'b1;
        end
        if (!rst && slave_overrun) begin
            abort_run("slave saw more writes without a response than MAX_OUTSTANDING");
        end
    end

    // Budget grows with every block started
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 40 * beats_sent + 200) begin
            abort_run($sformatf("timeout after %0d cycles, write path stopped", cycles));
        end
    end

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        base       = '0;
        count      = '0;
        data_valid = 1'b0;
        data       = '0;
        strb       = '0;
        stall_pct  = 7'd20;
        exp_resp   = '0;
        exp_err    = '0;
        beats_sent = 0;
        cycles     = 0;
        saw_stall  = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            exp_mem[i] = 8'(i ^ (i >> 8) ^ 8'h5a);
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int b = 0; b < 4; b++) begin
            run_block(rand_base(), rand_count(), 1'b1, 1'b0, '0);
        end
        finish_test("full_strobe");

        // Same region again, so partial strobes land on old data
        for (int b = 0; b < 6; b++) begin
            run_block(rand_base(), rand_count(), 1'b0, 1'b1, '0);
        end
        finish_test("partial_strobe");

        set_stall(85);
        saw_stall = 1'b0;
        run_block(32'h4000, 16'd64, 1'b0, 1'b0, '0);
        if (!saw_stall) begin
            abort_run("data_ready never fell while the slave stalled, FIFO never filled");
        end
        finish_test("stall_burst");

        set_stall(30);
        run_block(32'hef80, 16'd32, 1'b1, 1'b1, '0);
        run_block(32'hff00, 16'd20, 1'b0, 1'b0, '0);
        finish_test("err_region");

        set_stall(20);
        run_block(32'h8000, 16'd6, 1'b1, 1'b0, 32'h9000);
        finish_test("ignored_start");

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* sim.f */
verilog/wb_pkg.sv
verilog/wb_addr_gen.sv
verilog/wb_beat_fifo.sv
verilog/wb_axi_issue.sv
verilog/wb_resp_track.sv
verilog/wb_write_path.sv
test/tb_axi_mem.sv
test/tb_wb_write_path.sv
